/* hw/stackCpuPkg.sv */
package stackCpuPkg;

   localparam int AddrWidth = 12;
   localparam int DataWidth = 16;

   typedef logic [AddrWidth-1:0] addrWord_t;
   typedef logic [DataWidth-1:0] dataWord_t;

   // top nibble of the instruction word
   typedef enum logic [3:0] {
      OpPush = 4'h0,
      OpAsp  = 4'h4,
      OpCall = 4'h5,
      OpJa   = 4'h6,
      OpJp   = 4'h8,
      OpJn   = 4'h9,
      OpJz   = 4'hA,
      OpJnz  = 4'hB,
      OpJodd = 4'hC
   } opcode_t;

   localparam dataWord_t HaltWord = 16'hFFFF;

   typedef enum logic [2:0] {
      StIdle    = 3'd0,
      StFetch   = 3'd1,
      StDecode  = 3'd2,
      StExecute = 3'd3,
      StHalt    = 3'd4
   } cpuState_t;

   // one memory access, read when write is low
   typedef struct packed {
      addrWord_t address;
      dataWord_t wdata;
      logic      write;
   } busReq_t;

   typedef struct packed {
      opcode_t   op;
      addrWord_t target;
      logic      isHalt;
      logic      isCondJump;
   } decodedInstr_t;

endpackage

/* hw/memBusMaster.sv */
`timescale 1ns/1ps

module memBusMaster import stackCpuPkg::*; (
   input  logic      clk,
   input  logic      rstn,
   input  busReq_t   req,
   input  logic      issue,
   input  logic      valid,
   input  dataWord_t rdata,
   output addrWord_t address,
   output dataWord_t wdata,
   output logic      write,
   output logic      select,
   output logic      done,
   output dataWord_t readWord
);

   // request held on the bus until the memory answers
   always_ff @(posedge clk) begin
      if (!rstn) begin
         address <= '0;
         wdata   <= '0;
         write   <= 1'b0;
         select  <= 1'b0;
      end
      else if (issue) begin
         address <= req.address;
         wdata   <= req.wdata;
         write   <= req.write;
         select  <= 1'b1;
      end
      else if (valid && select) begin
         wdata  <= '0;
         write  <= 1'b0;
         select <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         done <= 1'b0;
      end
      else begin
         done <= valid && select;
      end
   end

   // rdata only meaningful in the valid cycle
   always_ff @(posedge clk) begin
      if (valid && select) begin
         readWord <= rdata;
      end
   end

endmodule

/* hw/instrDecode.sv */
`timescale 1ns/1ps

module instrDecode import stackCpuPkg::*; (
   input  logic          clk,
   input  logic          rstn,
   input  logic          load,
   input  dataWord_t     word,
   output decodedInstr_t instr
);

   dataWord_t instrReg;
   opcode_t   op;
   logic      condJump;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         instrReg <= '0;
      end
      else if (load) begin
         instrReg <= word;
      end
   end

   // unlisted opcodes pass through as raw values
   assign op = opcode_t'(instrReg[15:12]);

   always_comb begin
      case (op)
         OpJp, OpJn, OpJz, OpJnz, OpJodd: begin
            condJump = 1'b1;
         end
         default: begin
            condJump = 1'b0;
         end
      endcase
   end

   always_comb begin
      instr.op         = op;
      instr.target     = instrReg[AddrWidth-1:0];
      instr.isHalt     = (instrReg == HaltWord);
      instr.isCondJump = condJump;
   end

endmodule

/* hw/execSequencer.sv */
`timescale 1ns/1ps

module execSequencer import stackCpuPkg::*; #(
   parameter addrWord_t StackReset = '0
) (
   input  logic          clk,
   input  logic          rstn,
   input  decodedInstr_t instr,
   input  addrWord_t     pc,
   input  logic          busDone,
   input  dataWord_t     readWord,
   output busReq_t       busReq,
   output logic          busIssue,
   output logic          fetchLoad,
   output logic          pcAdvance,
   output logic          pcJump,
   output logic          popLoad,
   output logic          halt
);

   cpuState_t state;
   cpuState_t stateNext;
   addrWord_t sp;
   addrWord_t spNext;
   addrWord_t spBelow;
   addrWord_t retAddr;
   logic      busPending;
   logic      step;
   logic      stepNext;

   // stack grows downward
   assign spBelow = sp - 1'b1;
   assign retAddr = pc + 1'b1;

   assign halt      = (state == StHalt);
   assign fetchLoad = (state == StFetch) && busDone;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state      <= StIdle;
         sp         <= StackReset;
         step       <= 1'b0;
         busPending <= 1'b0;
      end
      else begin
         state <= stateNext;
         sp    <= spNext;
         step  <= stepNext;
         if (busIssue) begin
            busPending <= 1'b1;
         end
         else if (busDone) begin
            busPending <= 1'b0;
         end
      end
   end

   always_comb begin
      stateNext = state;
      spNext    = sp;
      stepNext  = step;
      busReq    = '0;
      busIssue  = 1'b0;
      pcAdvance = 1'b0;
      pcJump    = 1'b0;
      popLoad   = 1'b0;
      case (state)
         StIdle: begin
            stateNext = StFetch;
         end
         StFetch: begin
            if (!busPending) begin
               busIssue       = 1'b1;
               busReq.address = pc;
            end
            if (busDone) begin
               stateNext = StDecode;
            end
         end
         StDecode: begin
            stepNext = 1'b0;
            if (instr.isHalt) begin
               stateNext = StHalt;
            end
            else begin
               case (instr.op)
                  OpPush: begin
                     busIssue       = 1'b1;
                     busReq.address = instr.target;
                     stateNext      = StExecute;
                  end
                  OpCall: begin
                     busIssue  = 1'b1;
                     busReq    = '{address: spBelow,
                                   wdata: {{(DataWidth - AddrWidth){1'b0}}, retAddr},
                                   write: 1'b1};
                     spNext    = spBelow;
                     stateNext = StExecute;
                  end
                  OpAsp: begin
                     spNext    = instr.target;
                     pcAdvance = 1'b1;
                     stateNext = StFetch;
                  end
                  OpJa: begin
                     pcJump    = 1'b1;
                     stateNext = StFetch;
                  end
                  default: begin
                     if (instr.isCondJump) begin
                        // pop read at the top of stack
                        busIssue       = 1'b1;
                        busReq.address = sp;
                        stateNext      = StExecute;
                     end
                     else begin
                        pcAdvance = 1'b1;
                        stateNext = StFetch;
                     end
                  end
               endcase
            end
         end
         StExecute: begin
            if (busDone) begin
               if (instr.op == OpPush && !step) begin
                  // operand read back, now store it below sp
                  busIssue  = 1'b1;
                  busReq    = '{address: spBelow, wdata: readWord, write: 1'b1};
                  spNext    = spBelow;
                  stepNext  = 1'b1;
               end
               else if (instr.isCondJump) begin
                  popLoad  = 1'b1;
                  spNext   = sp + 1'b1;
                  stepNext = 1'b1;
               end
               else if (instr.op == OpCall) begin
                  pcJump    = 1'b1;
                  stateNext = StFetch;
               end
               else begin
                  pcAdvance = 1'b1;
                  stateNext = StFetch;
               end
            end
            else if (step && instr.isCondJump) begin
               // popped word is registered by now
               pcJump    = 1'b1;
               stateNext = StFetch;
            end
         end
         StHalt: begin
            stateNext = StHalt;
         end
         default: begin
            stateNext = StIdle;
         end
      endcase
   end

endmodule

/* hw/branchResult.sv */
`timescale 1ns/1ps

module branchResult import stackCpuPkg::*; #(
   parameter addrWord_t ResetVector = '0
) (
   input  logic          clk,
   input  logic          rstn,
   input  decodedInstr_t instr,
   input  dataWord_t     popWord,
   input  logic          popLoad,
   input  logic          pcAdvance,
   input  logic          pcJump,
   output addrWord_t     pc
);

   dataWord_t popReg;
   logic      positive;
   logic      zero;
   logic      odd;
   logic      jumpTaken;

   always_ff @(posedge clk) begin
      if (popLoad) begin
         popReg <= popWord;
      end
   end

   // flags of the popped word
   assign zero     = (popReg == '0);
   assign positive = !popReg[DataWidth-1] && !zero;
   assign odd      = popReg[0];

   always_comb begin
      case (instr.op)
         OpJp:         jumpTaken = positive;
         OpJn:         jumpTaken = !positive;
         OpJz:         jumpTaken = zero;
         OpJnz:        jumpTaken = !zero;
         OpJodd:       jumpTaken = odd;
         OpJa, OpCall: jumpTaken = 1'b1;
         default:      jumpTaken = 1'b0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         pc <= ResetVector;
      end
      else if (pcJump && jumpTaken) begin
         pc <= instr.target;
      end
      else if (pcJump || pcAdvance) begin
         pc <= pc + 1'b1;
      end
   end

endmodule

/* hw/stackCpu.sv */
`timescale 1ns/1ps

module stackCpu import stackCpuPkg::*; #(
   parameter addrWord_t StackReset  = '0,
   parameter addrWord_t ResetVector = '0
) (
   input  logic      clk,
   input  logic      rstn,
   output addrWord_t address,
   output dataWord_t wdata,
   output logic      write,
   output logic      select,
   output logic      halt,
   input  dataWord_t rdata,
   input  logic      valid
);

   busReq_t       busReq;
   logic          busIssue;
   logic          busDone;
   dataWord_t     readWord;
   logic          fetchLoad;
   decodedInstr_t instr;
   addrWord_t     pc;
   logic          pcAdvance;
   logic          pcJump;
   logic          popLoad;

   memBusMaster i_memBusMaster (
      .clk      (clk),
      .rstn     (rstn),
      .req      (busReq),
      .issue    (busIssue),
      .valid    (valid),
      .rdata    (rdata),
      .address  (address),
      .wdata    (wdata),
      .write    (write),
      .select   (select),
      .done     (busDone),
      .readWord (readWord)
   );

   instrDecode i_instrDecode (
      .clk   (clk),
      .rstn  (rstn),
      .load  (fetchLoad),
      .word  (readWord),
      .instr (instr)
   );

   execSequencer #(
      .StackReset (StackReset)
   ) i_execSequencer (
      .clk       (clk),
      .rstn      (rstn),
      .instr     (instr),
      .pc        (pc),
      .busDone   (busDone),
      .readWord  (readWord),
      .busReq    (busReq),
      .busIssue  (busIssue),
      .fetchLoad (fetchLoad),
      .pcAdvance (pcAdvance),
      .pcJump    (pcJump),
      .popLoad   (popLoad),
      .halt      (halt)
   );

   branchResult #(
      .ResetVector (ResetVector)
   ) i_branchResult (
      .clk       (clk),
      .rstn      (rstn),
      .instr     (instr),
      .popWord   (readWord),
      .popLoad   (popLoad),
      .pcAdvance (pcAdvance),
      .pcJump    (pcJump),
      .pc        (pc)
   );

endmodule

/* verification/stackCpuMem.sv */
`timescale 1ns/1ps

module stackCpuMem import stackCpuPkg::*; (
   input  logic      clk,
   input  logic      rstn,
   input  addrWord_t address,
   input  dataWord_t wdata,
   input  logic      write,
   input  logic      select,
   output dataWord_t rdata,
   output logic      valid
);

   dataWord_t   mem [0:(1 << AddrWidth) - 1];
   addrWord_t   logAddr [$];
   dataWord_t   logData [$];
   logic [31:0] lcgState = 32'hb170_d8d4;
   int          waitLeft = 0;
   int          latency;
   logic        validQ = 1'b0;
   dataWord_t   rdataQ = '0;

   assign valid = validQ;
   assign rdata = rdataQ;

   function automatic logic [31:0] lcgNext(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // answers after 1 to 4 cycles of select
   always @(posedge clk) begin
      validQ <= 1'b0;
      if (!rstn) begin
         waitLeft = 0;
      end
      else if (select && !validQ) begin
         if (waitLeft == 0) begin
            lcgState = lcgNext(lcgState);
            latency  = int'(lcgState[17:16]) + 1;
         end
         else begin
            latency = waitLeft;
         end
         if (latency == 1) begin
            validQ <= 1'b1;
            waitLeft = 0;
            if (write) begin
               mem[address] = wdata;
               logAddr.push_back(address);
               logData.push_back(wdata);
               rdataQ <= '0;
            end
            else begin
               rdataQ <= mem[address];
            end
         end
         else begin
            waitLeft = latency - 1;
         end
      end
   end

   task automatic fillMem();
      for (int i = 0; i < (1 << AddrWidth); i++) begin
         // opcode 7 is unused, stray fetches just fall through
         mem[i] = {4'h7, i[11:0]};
      end
   endtask

   task automatic loadWord(input addrWord_t a, input dataWord_t d);
      mem[a] = d;
   endtask

   task automatic clearLog();
      logAddr.delete();
      logData.delete();
   endtask

   function automatic int writeCount();
      return logAddr.size();
   endfunction

endmodule

/* verification/stackCpu_props.sv */
`timescale 1ns/1ps

module stackCpuProps import stackCpuPkg::*; (
   input logic      clk,
   input logic      rstn,
   input addrWord_t address,
   input dataWord_t wdata,
   input logic      write,
   input logic      select,
   input logic      halt,
   input logic      valid
);

   int failCount = 0;

   // request frozen while the memory has not answered
   holdUntilValid: assert property (@(posedge clk) disable iff (!rstn)
      select && !valid |=> select && $stable(address) && $stable(wdata) && $stable(write))
   else begin
      $error("bus request changed before valid");
      failCount++;
   end

   dropAfterValid: assert property (@(posedge clk) disable iff (!rstn)
      select && valid |=> !select)
   else begin
      $error("select still high in the cycle after valid");
      failCount++;
   end

   quietWhenHalted: assert property (@(posedge clk) disable iff (!rstn)
      halt |-> !select)
   else begin
      $error("bus selected while halted");
      failCount++;
   end

endmodule

bind stackCpu stackCpuProps i_stackCpuProps (
   .clk     (clk),
   .rstn    (rstn),
   .address (address),
   .wdata   (wdata),
   .write   (write),
   .select  (select),
   .halt    (halt),
   .valid   (valid)
);

/* verification/stackCpuTb.sv */
`timescale 1ns/1ps

module stackCpuTb import stackCpuPkg::*; ();

   localparam int ClkPeriod    = 8;
   localparam int ResetCycles  = 8;
   localparam int HoldCycles   = 20;
   localparam int NumTests     = 12;
   localparam int BusAccesses  = 12;
   localparam int AccessCycles = 6;
   // twice the worst bus time per test plus reset and the halt hold
   localparam int WatchdogNs   = NumTests * ClkPeriod
                                 * (2 * BusAccesses * AccessCycles + ResetCycles + HoldCycles);
   localparam dataWord_t Marker81 = 16'h5A81;
   localparam dataWord_t Marker82 = 16'hC382;

   typedef struct packed {
      opcode_t   op;
      dataWord_t value;
      logic      taken;
   } testCase_t;

   logic      clk = 1'b0;
   logic      rstn = 1'b0;
   addrWord_t address;
   dataWord_t wdata;
   logic      write;
   logic      select;
   logic      halt;
   dataWord_t rdata;
   logic      valid;
   testCase_t testTable [NumTests];
   int        errorCount = 0;
   int        passCount = 0;

   always #(ClkPeriod / 2) clk = ~clk;

   stackCpu #(
      .StackReset  (12'h000),
      .ResetVector (12'h000)
   ) i_stackCpu (
      .clk     (clk),
      .rstn    (rstn),
      .address (address),
      .wdata   (wdata),
      .write   (write),
      .select  (select),
      .halt    (halt),
      .rdata   (rdata),
      .valid   (valid)
   );

   stackCpuMem i_mem (
      .clk     (clk),
      .rstn    (rstn),
      .address (address),
      .wdata   (wdata),
      .write   (write),
      .select  (select),
      .rdata   (rdata),
      .valid   (valid)
   );

   task automatic checkData(input string name, input dataWord_t got, input dataWord_t exp);
      if (got !== exp) begin
         $display("MISMATCH at %0d ns: %s is %h, expected %h", $time, name, got, exp);
         errorCount++;
      end
   endtask

   task automatic checkAddr(input string name, input addrWord_t got, input addrWord_t exp);
      if (got !== exp) begin
         $display("MISMATCH at %0d ns: %s is %h, expected %h", $time, name, got, exp);
         errorCount++;
      end
   endtask

   task automatic checkFlag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("MISMATCH at %0d ns: %s is %b, expected %b", $time, name, got, exp);
         errorCount++;
      end
   endtask

   // expected flags worked out by hand from the branch rules
   task automatic fillTable();
      testTable[0]  = '{OpJp,   16'h0005, 1'b1};
      testTable[1]  = '{OpJp,   16'h0000, 1'b0};
      testTable[2]  = '{OpJp,   16'h8001, 1'b0};
      testTable[3]  = '{OpJn,   16'h8000, 1'b1};
      testTable[4]  = '{OpJn,   16'h0000, 1'b1};
      testTable[5]  = '{OpJn,   16'h7FFF, 1'b0};
      testTable[6]  = '{OpJz,   16'h0000, 1'b1};
      testTable[7]  = '{OpJz,   16'h0100, 1'b0};
      testTable[8]  = '{OpJnz,  16'h0001, 1'b1};
      testTable[9]  = '{OpJnz,  16'h0000, 1'b0};
      testTable[10] = '{OpJodd, 16'h1233, 1'b1};
      testTable[11] = '{OpJodd, 16'hFFFE, 1'b0};
   endtask

   task automatic loadProgram(input testCase_t tc);
      i_mem.fillMem();
      i_mem.clearLog();
      i_mem.loadWord(12'h000, 16'h4100);
      i_mem.loadWord(12'h001, 16'h0080);
      i_mem.loadWord(12'h002, {tc.op, 12'h020});
      i_mem.loadWord(12'h003, 16'h0081);
      i_mem.loadWord(12'h004, HaltWord);
      i_mem.loadWord(12'h020, 16'h0082);
      i_mem.loadWord(12'h021, 16'h5030);
      i_mem.loadWord(12'h030, HaltWord);
      i_mem.loadWord(12'h080, tc.value);
      i_mem.loadWord(12'h081, Marker81);
      i_mem.loadWord(12'h082, Marker82);
   endtask

   task automatic runTest(input int idx);
      testCase_t tc;
      int        errorsBefore;
      int        writes;
      int        expWrites;
      logic      holdBad;
      addrWord_t lastRead;
      tc = testTable[idx];
      errorsBefore = errorCount;
      holdBad = 1'b0;
      lastRead = '0;
      @(posedge clk);
      rstn <= 1'b0;
      loadProgram(tc);
      repeat (ResetCycles) @(posedge clk);
      checkFlag("select", select, 1'b0);
      checkFlag("write", write, 1'b0);
      checkFlag("halt", halt, 1'b0);
      checkAddr("address", address, 12'h000);
      checkData("wdata", wdata, 16'h0000);
      rstn <= 1'b1;
      do begin
         @(posedge clk);
      end while (!select);
      checkAddr("first fetch address", address, 12'h000);
      checkFlag("first fetch write", write, 1'b0);
      // last accepted read is the fetch of the HALT word
      do begin
         @(posedge clk);
         if (select && valid && !write) begin
            lastRead = address;
         end
      end while (!halt);
      repeat (HoldCycles) begin
         @(posedge clk);
         if (!halt || select) begin
            holdBad = 1'b1;
         end
      end
      if (holdBad) begin
         $display("test %0d: halt dropped or the bus was selected after HALT", idx);
         errorCount++;
      end
      checkFlag("jump taken", lastRead == 12'h030, tc.taken);
      writes = i_mem.writeCount();
      expWrites = tc.taken ? 3 : 2;
      if (writes != expWrites) begin
         $display("MISMATCH at %0d ns: write count is %0d, expected %0d",
                  $time, writes, expWrites);
         errorCount++;
      end
      if (writes >= 1) begin
         checkAddr("write 0 address", i_mem.logAddr[0], 12'h0FF);
         checkData("write 0 data", i_mem.logData[0], tc.value);
      end
      if (writes >= 2) begin
         checkAddr("write 1 address", i_mem.logAddr[1], 12'h0FF);
         checkData("write 1 data", i_mem.logData[1], tc.taken ? Marker82 : Marker81);
      end
      if (tc.taken && writes >= 3) begin
         checkAddr("return address slot", i_mem.logAddr[2], 12'h0FE);
         checkData("return address", i_mem.logData[2], 16'h0022);
      end
      if (errorCount == errorsBefore) begin
         passCount++;
         $display("test %0d %s value %h: ok", idx, tc.op.name(), tc.value);
      end
      else begin
         $display("test %0d %s value %h: failed", idx, tc.op.name(), tc.value);
      end
   endtask

   initial begin
      fillTable();
      for (int i = 0; i < NumTests; i++) begin
         runTest(i);
      end
      if (i_stackCpu.i_stackCpuProps.failCount != 0) begin
         $display("bus property failures: %0d", i_stackCpu.i_stackCpuProps.failCount);
         errorCount += i_stackCpu.i_stackCpuProps.failCount;
      end
      $display("%0d of %0d tests passed, %0d errors", passCount, NumTests, errorCount);
      if (errorCount == 0) begin
         $display("SIMULATION PASSED");
      end
      else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

   initial begin
      #(WatchdogNs);
      $display("watchdog expired after %0d ns, the DUT stopped making progress", WatchdogNs);
      $display("SIMULATION FAILED");
      $finish;
   end

endmodule

/* build.f */
hw/stackCpuPkg.sv
hw/memBusMaster.sv
hw/instrDecode.sv
hw/execSequencer.sv
hw/branchResult.sv
hw/stackCpu.sv
verification/stackCpuMem.sv
verification/stackCpu_props.sv
verification/stackCpuTb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := stackCpuTb
FILELIST  := build.f
BUILD_DIR := obj_dir
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) +verilator+error+limit+100 2>&1 | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
